//--- ifetch_config.svh
`ifndef IFETCH_CONFIG_SVH
`define IFETCH_CONFIG_SVH

// address and instruction width
`define IFETCH_ADDR_W 32

// first pc fetched after reset
`define IFETCH_PC_INIT 32'h8000_0000

// cache geometry of 4 lines with 2 words each
`define L1I_IDX_W 2
`define L1I_OFF_W 1

// credits held by fetch at reset with one per decode slot
`define IFETCH_CREDITS 4

`endif

//--- ifetch_pkg.sv
`default_nettype none

`include "ifetch_config.svh"

package ifetch_pkg;

  localparam int BYTE_OFF_W = 2;  // 4-byte instruction words
  localparam int TAG_W = `IFETCH_ADDR_W - `L1I_IDX_W - `L1I_OFF_W - BYTE_OFF_W;

  // fetch address read as a flat pc by fetch control and as fields by the cache
  typedef union packed {
    logic [`IFETCH_ADDR_W-1:0] pc;
    struct packed {
      logic [TAG_W-1:0]      tag;
      logic [`L1I_IDX_W-1:0] index;
      logic [`L1I_OFF_W-1:0] word_off;
      logic [BYTE_OFF_W-1:0] byte_off;
    } f;
  } fetch_addr_u;

  // rv32 major opcodes
  localparam logic [6:0] OP_JAL      = 7'b1101111;
  localparam logic [6:0] OP_JALR     = 7'b1100111;
  localparam logic [6:0] OP_BRANCH   = 7'b1100011;
  localparam logic [6:0] OP_SYSTEM   = 7'b1110011;
  localparam logic [6:0] OP_MISC_MEM = 7'b0001111;

  // fence.i is misc-mem with funct3 001 and all other fields zero
  localparam logic [31:0] INST_FENCE_I = {17'b0, 3'b001, 5'b0, OP_MISC_MEM};

endpackage

`default_nettype wire

//--- l1i_cache.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifetch_config.svh"

module l1i_cache (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      lookup_req_i,
  input  ifetch_pkg::fetch_addr_u   lookup_addr_i,
  input  logic                      inval_i,
  input  logic [`IFETCH_ADDR_W-1:0] mem_rdata_i,
  input  logic                      mem_rvalid_i,
  output logic                      hit_o,
  output logic [`IFETCH_ADDR_W-1:0] hit_word_o,
  output logic                      mem_arvalid_o,
  output logic [`IFETCH_ADDR_W-1:0] mem_araddr_o
);
  import ifetch_pkg::*;

  localparam int LINES = 1 << `L1I_IDX_W;
  localparam int WORDS = 1 << `L1I_OFF_W;

  localparam logic [1:0] RF_IDLE  = 2'd0;
  localparam logic [1:0] RF_WORD0 = 2'd1;
  localparam logic [1:0] RF_WORD1 = 2'd2;
  localparam logic [1:0] RF_DONE  = 2'd3;

  logic [TAG_W-1:0]          tag_q [LINES];
  logic [`IFETCH_ADDR_W-1:0] data_q [LINES][WORDS];
  logic [LINES-1:0]          valid_q;
  logic [1:0]                state_q;
  fetch_addr_u               refill_addr_q;
  fetch_addr_u               mem_addr;
  logic                      tag_match;
  logic                      word0_done;
  logic                      word1_done;

  assign tag_match = valid_q[lookup_addr_i.f.index] &&
                     (tag_q[lookup_addr_i.f.index] == lookup_addr_i.f.tag);

  // lookup is only answered while no refill is in progress
  assign hit_o      = lookup_req_i && (state_q == RF_IDLE) && tag_match;
  assign hit_word_o = data_q[lookup_addr_i.f.index][lookup_addr_i.f.word_off];

  assign word0_done = (state_q == RF_WORD0) && mem_rvalid_i;
  assign word1_done = (state_q == RF_WORD1) && mem_rvalid_i;

  always_comb begin
    mem_addr = refill_addr_q;
    mem_addr.f.word_off = (state_q == RF_WORD1) ? `L1I_OFF_W'(1) : `L1I_OFF_W'(0);
  end

  assign mem_arvalid_o = (state_q == RF_WORD0) || (state_q == RF_WORD1);
  assign mem_araddr_o  = mem_addr.pc;

  // refill fsm
  always_ff @(posedge clk) begin
    if (rst) begin
      state_q <= RF_IDLE;
    end else begin
      case (state_q)
        RF_IDLE: begin
          if (lookup_req_i && !tag_match) begin  // miss starts a refill
            state_q <= RF_WORD0;
          end
        end
        RF_WORD0: begin
          if (mem_rvalid_i) begin
            state_q <= RF_WORD1;
          end
        end
        RF_WORD1: begin
          if (mem_rvalid_i) begin
            state_q <= RF_DONE;
          end
        end
        default: begin
          state_q <= RF_IDLE;
        end
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      valid_q <= '0;
    end else begin
      if (inval_i) begin
        valid_q <= '0;
      end
      if (word0_done) begin
        valid_q[refill_addr_q.f.index] <= 1'b0;  // tag is being replaced
      end
      // set last so a flush during the refill keeps this line
      if (state_q == RF_DONE) begin
        valid_q[refill_addr_q.f.index] <= 1'b1;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state_q == RF_IDLE) begin
      refill_addr_q <= lookup_addr_i;  // frozen once the refill starts
    end
    if (word0_done) begin
      tag_q[refill_addr_q.f.index] <= refill_addr_q.f.tag;
      data_q[refill_addr_q.f.index][`L1I_OFF_W'(0)] <= mem_rdata_i;
    end
    if (word1_done) begin
      data_q[refill_addr_q.f.index][`L1I_OFF_W'(1)] <= mem_rdata_i;
    end
  end

  // request held with a fixed address until the read data returns
  a_ar_stable: assert property (@(posedge clk) disable iff (rst)
    mem_arvalid_o && !mem_rvalid_i |=> mem_arvalid_o && $stable(mem_araddr_o));

  a_ar_align: assert property (@(posedge clk) disable iff (rst)
    mem_arvalid_o |-> (mem_araddr_o[1:0] == 2'b00));

endmodule

`default_nettype wire

//--- fetch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifetch_config.svh"

module fetch_ctrl (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      credit_return_i,
  input  logic                      redirect_valid_i,
  input  logic [`IFETCH_ADDR_W-1:0] redirect_pc_i,
  input  logic                      hit_i,
  input  logic [`IFETCH_ADDR_W-1:0] hit_word_i,
  output logic                      lookup_req_o,
  output ifetch_pkg::fetch_addr_u   lookup_addr_o,
  output logic                      inval_o,
  output logic                      inst_valid_o,
  output logic [`IFETCH_ADDR_W-1:0] inst_o,
  output logic [`IFETCH_ADDR_W-1:0] pc_o
);
  import ifetch_pkg::*;

  localparam int CNT_W = $clog2(`IFETCH_CREDITS + 1);

  fetch_addr_u      pc_q;
  logic             stall_q;
  logic [CNT_W-1:0] credit_q;
  logic [6:0]       opcode;
  logic             is_ctrl_flow;
  logic             issue;

  assign opcode       = hit_word_i[6:0];
  assign is_ctrl_flow = opcode inside {OP_JAL, OP_JALR, OP_BRANCH, OP_SYSTEM};

  assign lookup_req_o  = !stall_q;  // no lookups while waiting on execute
  assign lookup_addr_o = pc_q;

  // a hit with a credit in hand issues this cycle
  assign issue   = lookup_req_o && hit_i && (credit_q != '0);
  assign inval_o = issue && (hit_word_i == INST_FENCE_I);

  // pc and control-flow stall
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q.pc <= `IFETCH_PC_INIT;
      stall_q <= 1'b0;
    end else if (redirect_valid_i) begin
      pc_q.pc <= redirect_pc_i;  // taken or not, execute sends the next pc
      stall_q <= 1'b0;
    end else if (issue) begin
      if (is_ctrl_flow) begin
        stall_q <= 1'b1;
      end else begin
        pc_q.pc <= pc_q.pc + `IFETCH_ADDR_W'(4);
      end
    end
  end

  // downstream credits
  always_ff @(posedge clk) begin
    if (rst) begin
      credit_q <= CNT_W'(`IFETCH_CREDITS);
    end else begin
      credit_q <= credit_q + CNT_W'(credit_return_i) - CNT_W'(issue);
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      inst_valid_o <= 1'b0;
    end else begin
      inst_valid_o <= issue;
    end
  end

  always_ff @(posedge clk) begin
    if (issue) begin
      inst_o <= hit_word_i;
      pc_o   <= pc_q.pc;
    end
  end

  // decode never hands back more than it was given
  a_credit_max: assert property (@(posedge clk) disable iff (rst)
    credit_q <= CNT_W'(`IFETCH_CREDITS));

  // execute redirects only a stalled control-flow instruction
  a_redirect_stalled: assert property (@(posedge clk) disable iff (rst)
    redirect_valid_i |-> stall_q);

endmodule

`default_nettype wire

//--- ifetch_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifetch_config.svh"

module ifetch_top (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      credit_return_i,
  input  logic                      redirect_valid_i,
  input  logic [`IFETCH_ADDR_W-1:0] redirect_pc_i,
  input  logic [`IFETCH_ADDR_W-1:0] mem_rdata_i,
  input  logic                      mem_rvalid_i,
  output logic                      inst_valid_o,
  output logic [`IFETCH_ADDR_W-1:0] inst_o,
  output logic [`IFETCH_ADDR_W-1:0] pc_o,
  output logic                      mem_arvalid_o,
  output logic [`IFETCH_ADDR_W-1:0] mem_araddr_o
);
  import ifetch_pkg::*;

  logic                      lookup_req;
  fetch_addr_u               lookup_addr;
  logic                      inval;
  logic                      hit;
  logic [`IFETCH_ADDR_W-1:0] hit_word;

  fetch_ctrl fetch_ctrl_i (
    .clk              (clk),
    .rst              (rst),
    .credit_return_i  (credit_return_i),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .hit_i            (hit),
    .hit_word_i       (hit_word),
    .lookup_req_o     (lookup_req),
    .lookup_addr_o    (lookup_addr),
    .inval_o          (inval),
    .inst_valid_o     (inst_valid_o),
    .inst_o           (inst_o),
    .pc_o             (pc_o)
  );

  l1i_cache l1i_cache_i (
    .clk           (clk),
    .rst           (rst),
    .lookup_req_i  (lookup_req),
    .lookup_addr_i (lookup_addr),
    .inval_i       (inval),
    .mem_rdata_i   (mem_rdata_i),
    .mem_rvalid_i  (mem_rvalid_i),
    .hit_o         (hit),
    .hit_word_o    (hit_word),
    .mem_arvalid_o (mem_arvalid_o),
    .mem_araddr_o  (mem_araddr_o)
  );

endmodule

`default_nettype wire

//--- tb_mem_model.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifetch_config.svh"

module tb_mem_model #(
  parameter int          WORDS     = 32,
  parameter logic [31:0] JAL_OFF   = 32'h18,
  parameter logic [31:0] FENCE_OFF = 32'h40
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic                      arvalid_i,
  input  logic [`IFETCH_ADDR_W-1:0] araddr_i,
  input  logic [2:0]                delay_i,
  output logic                      rvalid_o,
  output logic [`IFETCH_ADDR_W-1:0] rdata_o
);
  import ifetch_pkg::*;

  localparam logic [6:0]  OP_IMM = 7'b0010011;
  localparam logic [31:0] JAL_X0 = {25'b0, OP_JAL};  // jal x0, 0

  logic [`IFETCH_ADDR_W-1:0] image [WORDS];
  logic                      busy;
  logic [2:0]                delay_seen;
  int                        wait_cnt;

  // addi whose fields fold in every address bit above the byte offset
  function automatic logic [31:0] fill_word(input logic [31:0] addr);
    return {addr[13:2] ^ addr[25:14], addr[30:26], 3'b000, addr[31], addr[29:26], OP_IMM};
  endfunction

  function automatic logic [31:0] read_word(input logic [31:0] addr);
    logic [31:0] off;
    off = addr - `IFETCH_PC_INIT;
    if (off >= 4 * WORDS) begin
      return 'x;  // outside the program
    end
    return image[off >> 2];
  endfunction

  initial begin
    for (int i = 0; i < WORDS; i++) begin
      image[i] = fill_word(`IFETCH_PC_INIT + 4 * i);
    end
    image[JAL_OFF >> 2]         = JAL_X0;  // closes the loop
    image[FENCE_OFF >> 2]       = INST_FENCE_I;
    image[(FENCE_OFF >> 2) + 1] = JAL_X0;
  end

  // one word per request answered delay_i cycles after it is seen
  initial begin
    rvalid_o = 1'b0;
    rdata_o  = '0;
    busy     = 1'b0;
    wait_cnt = 0;
    forever begin
      @(posedge clk);
      delay_seen = delay_i;  // value driven after the previous edge
      #1;
      rvalid_o = 1'b0;
      if (rst) begin
        busy = 1'b0;
      end else if (!busy && arvalid_i) begin
        busy     = 1'b1;
        wait_cnt = delay_seen;
      end
      if (busy) begin
        if (wait_cnt <= 1) begin
          rvalid_o = 1'b1;
          rdata_o  = read_word(araddr_i);
          busy     = 1'b0;
        end else begin
          wait_cnt--;
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- tb_ifetch_top.sv
`timescale 1ns/1ps
`default_nettype none

`include "ifetch_config.svh"

module tb_ifetch_top;
  import ifetch_pkg::*;

  localparam int          CLK_PERIOD   = 10;
  localparam int          RESET_CYCLES = 16;
  localparam int          IMAGE_WORDS  = 32;
  localparam logic [31:0] PC_INIT      = `IFETCH_PC_INIT;
  localparam logic [31:0] JAL_OFF      = 32'h18;
  localparam logic [31:0] FENCE_OFF    = 32'h40;
  localparam int          MAX_DELAY    = 4;
  localparam int          REFILL_WORST = 2 * (MAX_DELAY + 1) + 4;  // two reads, lookup, issue
  localparam int          NUM_TESTS    = 6;
  localparam int          STALL_LIMIT  = IMAGE_WORDS * REFILL_WORST;

  logic                      clk;
  logic                      rst;
  logic                      credit_return_i;
  logic                      redirect_valid_i;
  logic [`IFETCH_ADDR_W-1:0] redirect_pc_i;
  logic [`IFETCH_ADDR_W-1:0] mem_rdata_i;
  logic                      mem_rvalid_i;
  logic                      inst_valid_o;
  logic [`IFETCH_ADDR_W-1:0] inst_o;
  logic [`IFETCH_ADDR_W-1:0] pc_o;
  logic                      mem_arvalid_o;
  logic [`IFETCH_ADDR_W-1:0] mem_araddr_o;
  logic [2:0]                mem_delay;

  string       test_name = "none";
  int          errors = 0;
  int          err_at_open = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          issue_count = 0;
  int          outstanding = 0;  // issued but not yet returned by decode
  int          mem_reads = 0;
  int          ar_cycles = 0;
  logic        stalled = 1'b0;
  logic        withhold = 1'b0;
  logic [31:0] expected_pc = `IFETCH_PC_INIT;
  logic [31:0] rng_state = 32'd61;

  ifetch_top ifetch_top_i (
    .clk              (clk),
    .rst              (rst),
    .credit_return_i  (credit_return_i),
    .redirect_valid_i (redirect_valid_i),
    .redirect_pc_i    (redirect_pc_i),
    .mem_rdata_i      (mem_rdata_i),
    .mem_rvalid_i     (mem_rvalid_i),
    .inst_valid_o     (inst_valid_o),
    .inst_o           (inst_o),
    .pc_o             (pc_o),
    .mem_arvalid_o    (mem_arvalid_o),
    .mem_araddr_o     (mem_araddr_o)
  );

  tb_mem_model #(.WORDS(IMAGE_WORDS), .JAL_OFF(JAL_OFF), .FENCE_OFF(FENCE_OFF)) tb_mem_model_i (
    .clk       (clk),
    .rst       (rst),
    .arvalid_i (mem_arvalid_o),
    .araddr_i  (mem_araddr_o),
    .delay_i   (mem_delay),
    .rvalid_o  (mem_rvalid_i),
    .rdata_o   (mem_rdata_i)
  );

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  function automatic logic [31:0] image_word(input logic [31:0] addr);
    logic [31:0] off;
    off = addr - PC_INIT;
    if (off >= 4 * IMAGE_WORDS) begin
      return 'x;
    end
    return tb_mem_model_i.image[off >> 2];
  endfunction

  function automatic logic is_ctrl_flow(input logic [31:0] word);
    return (word[6:0] == OP_JAL) || (word[6:0] == OP_JALR) ||
           (word[6:0] == OP_BRANCH) || (word[6:0] == OP_SYSTEM);
  endfunction

  task automatic note_failure(input string msg);
    $display("%s: %s", test_name, msg);
    errors++;
  endtask

  task automatic check_value(input string what, input logic [31:0] exp, input logic [31:0] act);
    assert (act === exp) else begin
      $display("[ERROR] %s: %s expected %h actual %h", test_name, what, exp, act);
      errors++;
    end
  endtask

  task automatic open_test(input string name);
    test_name   = name;
    err_at_open = errors;
  endtask

  task automatic close_test();
    tests_run++;
    if (errors == err_at_open) begin
      $display("test %s: ok", test_name);
    end else begin
      tests_failed++;
      $display("test %s: failed with %0d errors", test_name, errors - err_at_open);
    end
  endtask

  // called 1 ns after an edge and returns 1 ns after the edge that takes it
  task automatic redirect_to(input logic [31:0] target);
    redirect_pc_i    = target;
    redirect_valid_i = 1'b1;
    expected_pc      = target;
    stalled          = 1'b0;
    @(posedge clk);
    #1;
    redirect_valid_i = 1'b0;
  endtask

  task automatic run_until_stall();
    int cycles;
    cycles = 0;
    while (!stalled && cycles < STALL_LIMIT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    assert (stalled) else note_failure("no control-flow instruction issued in time");
  endtask

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // decode returns credits at random times and the memory delay is redrawn each cycle
  initial begin
    logic withheld;
    credit_return_i = 1'b0;
    mem_delay       = 3'd1;
    forever begin
      @(posedge clk);
      withheld = withhold;
      #1;
      rng_state       = xorshift32(rng_state);
      mem_delay       = 3'(1 + rng_state[1:0]);
      credit_return_i = !withheld && (outstanding > 0) && rng_state[7];
    end
  end

  always @(posedge clk) begin
    if (!rst) begin
      if (mem_arvalid_o) begin
        ar_cycles++;
      end
      if (mem_arvalid_o && mem_rvalid_i) begin
        // reads alternate between word 0 and word 1 of a line
        check_value("mem_araddr_o[2:0]", {29'b0, mem_reads[0], 2'b00},
                    {29'b0, mem_araddr_o[2:0]});
        mem_reads++;
      end
      if (credit_return_i) begin
        outstanding--;
      end
      if (inst_valid_o) begin
        issue_count++;
        outstanding++;
        assert (!stalled) else note_failure("instruction issued while waiting for a redirect");
        assert (pc_o - PC_INIT < 4 * IMAGE_WORDS) else note_failure("pc_o left the program");
        check_value("pc_o", expected_pc, pc_o);
        check_value("inst_o", image_word(expected_pc), inst_o);
        if (is_ctrl_flow(image_word(expected_pc))) begin
          stalled = 1'b1;  // next pc comes from the redirect
        end
        expected_pc = expected_pc + 4;
      end
      assert (outstanding <= `IFETCH_CREDITS)
        else note_failure("more issues in flight than credits");
    end
  end

  initial begin
    #(NUM_TESTS * REFILL_WORST * IMAGE_WORDS * CLK_PERIOD);
    $display("watchdog expired before the tests finished");
    $display("** FAIL **");
    $finish;
  end

  initial begin
    int n0;
    int r0;
    int cycles;
    rst              = 1'b1;
    redirect_valid_i = 1'b0;
    redirect_pc_i    = '0;

    open_test("reset");
    for (int c = 0; c <= RESET_CYCLES; c++) begin
      @(posedge clk);
      if (c > 0) begin  // last pass is the first edge after release
        check_value("inst_valid_o", 0, inst_valid_o);
        check_value("mem_arvalid_o", 0, mem_arvalid_o);
      end
      #1;
      if (c == RESET_CYCLES - 1) begin
        rst = 1'b0;
      end
    end
    close_test();

    open_test("stream");
    n0 = issue_count;
    run_until_stall();
    check_value("issues up to jal", JAL_OFF / 4 + 1, issue_count - n0);
    close_test();

    open_test("stall");
    n0 = issue_count;
    repeat (10) begin
      @(posedge clk);
      #1;
    end
    check_value("issues while stalled", 0, issue_count - n0);
    r0 = ar_cycles;
    redirect_to(PC_INIT);
    cycles = 0;
    while (issue_count == n0 && cycles < STALL_LIMIT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    assert (issue_count > n0) else note_failure("nothing issued after the redirect");
    close_test();

    open_test("hits");
    run_until_stall();
    check_value("mem_arvalid_o cycles", 0, ar_cycles - r0);
    close_test();

    open_test("credits");
    cycles = 0;
    while (outstanding > 0 && cycles < STALL_LIMIT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    assert (outstanding == 0) else note_failure("decode never returned its credits");
    withhold = 1'b1;
    redirect_to(PC_INIT);
    cycles = 0;
    while (outstanding < `IFETCH_CREDITS && cycles < STALL_LIMIT) begin
      @(posedge clk);
      #1;
      cycles++;
    end
    assert (outstanding == `IFETCH_CREDITS) else note_failure("credits were never used up");
    n0 = issue_count;
    repeat (20) begin
      @(posedge clk);
      #1;
    end
    check_value("issues without credits", 0, issue_count - n0);
    withhold = 1'b0;
    run_until_stall();
    close_test();

    open_test("fence_i");
    redirect_to(PC_INIT + FENCE_OFF);
    run_until_stall();  // fence.i and the jal after it
    r0 = mem_reads;
    redirect_to(PC_INIT);
    run_until_stall();
    check_value("refill reads in loop", 2 * (JAL_OFF / 8 + 1), mem_reads - r0);
    close_test();

    $display("tests run %0d, passed %0d, failed %0d, errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (tests_failed == 0 && errors == 0) begin
      $display("** PASS **");
    end else begin
      $display("** FAIL **");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
+incdir+.
ifetch_pkg.sv
l1i_cache.sv
fetch_ctrl.sv
ifetch_top.sv
tb_mem_model.sv
tb_ifetch_top.sv
